//--- fetchUnit.f
hdl/fetchPkg.sv
hdl/phaseSequencer.sv
hdl/branchDecoder.sv
hdl/programCounter.sv
hdl/fetchPort.sv
hdl/fetchUnit.sv
tb/fetchUnit_props.sv
tb/fetchUnitTb.sv

//--- Makefile
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetchUnitTb
FILELIST  ?= fetchUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Test run passed"; \
	else \
		echo "Test run failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/fetchUnitTb.sv
//********************
// Fetch unit testbench
// Program memory model, reference next address and directed tests
//********************
`timescale 1ns/1ps

module fetchUnitTb import fetchPkg::*; ();

	localparam int NUM_INSTR = 90;
	localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 120;

	logic        CLK;
	logic        RESET;
	logic        run;
	logic        irq0;
	logic        irq1;
	logic [15:0] regB;
	logic [15:0] instrData;
	bkpCmd_t     bkpCmd;
	logic [15:0] memAddr;
	logic        memRead;
	logic [15:0] here;
	logic        atBkp;
	logic        intAck0;
	logic        intAck1;
	phase_t      phase;

	logic [15:0] progMem [256];
	logic [15:0] lfsrState;
	int          cycleCount;
	int          ack0Count;
	int          ack1Count;

	// Reference model state
	logic [15:0] curPc;
	logic [15:0] curWord;
	logic        smp0;
	logic        smp1;
	logic        svc0;
	logic        svc1;
	logic [15:0] ret0;
	logic [15:0] ret1;
	logic [15:0] pendPc;
	logic        pendSvc0;
	logic        pendSvc1;
	logic [15:0] pendRet0;
	logic [15:0] pendRet1;

	fetchUnit u_dut (
		.CLK       (CLK),
		.RESET     (RESET),
		.run       (run),
		.irq0      (irq0),
		.irq1      (irq1),
		.regB      (regB),
		.instrData (instrData),
		.bkpCmd    (bkpCmd),
		.memAddr   (memAddr),
		.memRead   (memRead),
		.here      (here),
		.atBkp     (atBkp),
		.intAck0   (intAck0),
		.intAck1   (intAck1),
		.phase     (phase)
	);

	always #10 CLK = ~CLK;

	// Combinational program memory
	assign instrData = progMem[memAddr[8:1]];

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic drawBits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			val = {val[14:0], lfsrState[0]};
		end
	endtask

	function automatic logic isBranch(input logic [3:0] op);
		return (op == OP_JMP) || (op == OP_JR) || (op == OP_JREG) || (op == OP_RETI);
	endfunction

	// Expected next address from the instruction rules
	function automatic logic [15:0] refNextAddr(input logic [15:0] pc, input logic [15:0] word,
		input logic [15:0] rb, input logic s0, input logic s1, input logic inSvc0,
		input logic inSvc1, input logic [15:0] r0, input logic [15:0] r1);
		logic [3:0]  op;
		logic [11:0] imm;
		op = word[15:12];
		imm = word[11:0];
		if (op == OP_JMP) begin
			return {3'b000, imm, 1'b0};
		end else if (op == OP_JR) begin
			return pc + {{3{imm[11]}}, imm, 1'b0};
		end else if (op == OP_JREG) begin
			return rb;
		end else if (op == OP_RETI) begin
			return inSvc0 ? r0 : r1;
		end else if (s0 && !inSvc0) begin
			return INTV0;
		end else if (s1 && !inSvc0 && !inSvc1) begin
			return INTV1;
		end
		return pc + 16'd2;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	task automatic putWord(input logic [15:0] addr, input logic [15:0] word);
		progMem[addr[8:1]] = word;
	endtask

	task automatic waitDecodeAt(input logic [15:0] addr);
		do begin
			@(negedge CLK);
		end while (!(phase == DECODE && memAddr == addr));
	endtask

	// Compare process, follows the DUT one instruction at a time
	always @(negedge CLK) begin
		if (!RESET) begin
			if (phase == FETCH) begin
				pendPc = refNextAddr(curPc, curWord, regB, smp0, smp1, svc0, svc1, ret0, ret1);
				pendSvc0 = svc0;
				pendSvc1 = svc1;
				pendRet0 = ret0;
				pendRet1 = ret1;
				if (curWord[15:12] == OP_RETI) begin
					if (svc0) begin
						pendSvc0 = 1'b0;
					end else begin
						pendSvc1 = 1'b0;
					end
				end else if (!isBranch(curWord[15:12])) begin
					if (smp0 && !svc0) begin
						pendSvc0 = 1'b1;
						pendRet0 = curPc + 16'd2;
					end else if (smp1 && !svc0 && !svc1) begin
						pendSvc1 = 1'b1;
						pendRet1 = curPc + 16'd2;
					end
				end
				if (intAck0) ack0Count++;
				if (intAck1) ack1Count++;
			end else if (phase == DECODE) begin
				curPc = pendPc;
				svc0 = pendSvc0;
				svc1 = pendSvc1;
				ret0 = pendRet0;
				ret1 = pendRet1;
				checkValue("fetchAddr", curPc, memAddr);
				checkValue("here", curPc + 16'd2, here);
				checkValue("memRead", 16'd1, {15'd0, memRead});
				curWord = progMem[curPc[8:1]];
				smp0 = irq0;
				smp1 = irq1;
			end
		end
	end

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount > TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1, "cycle limit reached");
		end
	end

	initial begin
		logic [15:0] r;
		logic [15:0] tgt [8];
		logic [15:0] irqSlot;
		logic [15:0] frozen;
		int          blockOrder [8];
		blockOrder = '{4, 1, 6, 2, 7, 3, 5, 0};
		CLK = 1'b0;
		RESET = 1'b1;
		run = 1'b0;
		irq0 = 1'b0;
		irq1 = 1'b0;
		bkpCmd = '0;
		cycleCount = 0;
		ack0Count = 0;
		ack1Count = 0;
		lfsrState = 16'd56;
		curPc = PC_RESET;
		curWord = NOP_WORD;
		{smp0, smp1, svc0, svc1} = 4'b0000;
		ret0 = '0;
		ret1 = '0;

		// Unused opcode F with the word index, decodes as NOP
		for (int i = 0; i < 256; i++) begin
			progMem[i] = 16'hF000 | 16'(i);
		end
		putWord(16'h0002, {OP_JMP, 12'h040});
		putWord(16'h0004, {OP_JMP, 12'h020});
		putWord(16'h0008, {OP_JMP, 12'h030});
		putWord(16'h0042, {OP_RETI, 12'h000});
		putWord(16'h0066, {OP_RETI, 12'h000});
		putWord(16'h00C0, {OP_JMP, 12'h062});

		// Random jump chain across blocks, some hops go backwards
		for (int i = 0; i < 8; i++) begin
			drawBits(3, r);
			tgt[i] = 16'h0100 + 16'(blockOrder[i]) * 16'h0020 + (r << 1);
		end
		putWord(16'h0090, {OP_JMP, tgt[0][12:1]});
		for (int i = 0; i < 7; i++) begin
			if (i % 2 == 0) begin
				r = tgt[i + 1] - tgt[i];
				putWord(tgt[i], {OP_JR, r[12:1]});
			end else begin
				putWord(tgt[i], {OP_JMP, tgt[i + 1][12:1]});
			end
		end
		putWord(tgt[7], {OP_JREG, 12'h000});
		drawBits(3, r);
		regB = 16'h00A0 + (r << 1);

		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0;
		@(negedge CLK);
		run = 1'b1;

		// NOP run, jumps and register jump
		waitDecodeAt(16'h0000);
		waitDecodeAt(16'h008E);
		waitDecodeAt(tgt[7]);
		waitDecodeAt(regB);

		// Nested interrupts
		drawBits(2, r);
		irqSlot = 16'h00B0 + (r << 1);
		waitDecodeAt(irqSlot);
		@(negedge CLK);
		irq1 = 1'b1;
		waitDecodeAt(INTV1);
		checkValue("ack1AfterIrq1", 16'd1, 16'(ack1Count));
		@(negedge CLK);
		irq1 = 1'b0;
		waitDecodeAt(16'h0060);
		@(negedge CLK);
		irq0 = 1'b1;
		waitDecodeAt(INTV0);
		checkValue("ack0AfterIrq0", 16'd1, 16'(ack0Count));
		@(negedge CLK);
		irq0 = 1'b0;
		waitDecodeAt(16'h0064);
		waitDecodeAt(irqSlot + 16'd4);

		// Request during a jump waits for the NOP at the target
		waitDecodeAt(16'h00BE);
		@(negedge CLK);
		irq1 = 1'b1;
		waitDecodeAt(INTV1);
		checkValue("ack1Deferred", 16'd2, 16'(ack1Count));
		@(negedge CLK);
		irq1 = 1'b0;
		waitDecodeAt(16'h00C6);

		// Breakpoint at 0x00D0
		waitDecodeAt(16'h00C8);
		@(negedge CLK);
		bkpCmd = '{load: 1'b1, enable: 1'b1, addr: 16'h00D0};
		@(negedge CLK);
		bkpCmd.load = 1'b0;
		do begin
			@(negedge CLK);
		end while (!atBkp);
		frozen = memAddr;
		checkValue("bkpAddr", 16'h00CE, frozen);
		run = 1'b0;
		repeat (2) @(negedge CLK);
		run = 1'b1;
		repeat (3) @(negedge CLK);
		checkValue("bkpHeld", 16'd1, {15'd0, atBkp});
		checkValue("bkpFrozen", frozen, memAddr);
		checkValue("bkpPhase", {14'd0, FETCH}, {14'd0, phase});
		bkpCmd = '{load: 1'b1, enable: 1'b0, addr: 16'h00D0};
		@(negedge CLK);
		bkpCmd.load = 1'b0;
		waitDecodeAt(16'h00D0);
		checkValue("bkpCleared", 16'd0, {15'd0, atBkp});

		// Run low parks the sequencer in FETCH
		waitDecodeAt(16'h00D4);
		@(negedge CLK);
		run = 1'b0;
		repeat (2) @(negedge CLK);
		repeat (8) begin
			@(negedge CLK);
			checkValue("runLowPhase", {14'd0, FETCH}, {14'd0, phase});
			checkValue("runLowRead", 16'd0, {15'd0, memRead});
		end
		run = 1'b1;
		waitDecodeAt(16'h00E0);

		if (u_dut.u_props.assertFails != 0) begin
			$display("Simulation finished: FAIL");
		end else begin
			$display("Simulation finished: PASS");
		end
		$finish;
	end

endmodule

//--- tb/fetchUnit_props.sv
//********************
// Fetch unit properties
// Bus and sequencing rules, bound to fetchUnit
//********************
`timescale 1ns/1ps

module fetchUnitProps import fetchPkg::*; (
	input logic        CLK,
	input logic        RESET,
	input logic        memRead,
	input logic [15:0] memAddr,
	input logic        atBkp,
	input logic        intAck0,
	input logic        intAck1,
	input phase_t      phase
);

	int assertFails = 0;

	// Memory is read only in DECODE
	assert property (@(posedge CLK) disable iff (RESET) memRead |-> phase == DECODE)
		else begin
			assertFails++;
			$error("memRead outside DECODE");
		end

	// Acknowledges are single FETCH cycle pulses
	assert property (@(posedge CLK) disable iff (RESET)
		intAck0 |-> phase == FETCH ##1 !intAck0)
		else begin
			assertFails++;
			$error("intAck0 not a single FETCH pulse");
		end

	assert property (@(posedge CLK) disable iff (RESET)
		intAck1 |-> phase == FETCH ##1 !intAck1)
		else begin
			assertFails++;
			$error("intAck1 not a single FETCH pulse");
		end

	// Address frozen while parked
	assert property (@(posedge CLK) disable iff (RESET) atBkp |=> $stable(memAddr))
		else begin
			assertFails++;
			$error("memAddr moved while at breakpoint");
		end

	assert property (@(posedge CLK) disable iff (RESET) phase == COMMIT |=> phase == FETCH)
		else begin
			assertFails++;
			$error("COMMIT not followed by FETCH");
		end

endmodule

bind fetchUnit fetchUnitProps u_props (.*);

//--- hdl/fetchUnit.sv
//********************
// Instruction fetch unit
// Sequencer, decoder, program counter and fetch port
//********************
`timescale 1ns/1ps

module fetchUnit import fetchPkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  logic        run,
	input  logic        irq0,
	input  logic        irq1,
	input  logic [15:0] regB,
	input  logic [15:0] instrData,
	input  bkpCmd_t     bkpCmd,
	output logic [15:0] memAddr,
	output logic        memRead,
	output logic [15:0] here,
	output logic        atBkp,
	output logic        intAck0,
	output logic        intAck1,
	output phase_t      phase
);

	logic              pcEnable;
	logic [15:0]       instrReg;
	logic [ADDR_W-1:0] pcAddr;
	pcControl_t        ctrl;

	phaseSequencer u_phaseSequencer (
		.CLK      (CLK),
		.RESET    (RESET),
		.run      (run),
		.atBkp    (atBkp),
		.phase    (phase),
		.pcEnable (pcEnable)
	);

	branchDecoder u_branchDecoder (
		.CLK      (CLK),
		.RESET    (RESET),
		.phase    (phase),
		.pcEnable (pcEnable),
		.instrReg (instrReg),
		.irq0     (irq0),
		.irq1     (irq1),
		.ctrl     (ctrl),
		.intAck0  (intAck0),
		.intAck1  (intAck1)
	);

	programCounter u_programCounter (
		.CLK      (CLK),
		.RESET    (RESET),
		.pcEnable (pcEnable),
		.phase    (phase),
		.ctrl     (ctrl),
		.regB     (regB),
		.bkpCmd   (bkpCmd),
		.pcAddr   (pcAddr),
		.here     (here),
		.atBkp    (atBkp)
	);

	fetchPort u_fetchPort (
		.CLK       (CLK),
		.RESET     (RESET),
		.phase     (phase),
		.pcAddr    (pcAddr),
		.instrData (instrData),
		.memAddr   (memAddr),
		.memRead   (memRead),
		.instrReg  (instrReg)
	);

endmodule

//--- hdl/fetchPort.sv
//********************
// Fetch port
// Memory read in DECODE and instruction register latch
//********************
`timescale 1ns/1ps

module fetchPort import fetchPkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  phase_t      phase,
	input  logic [15:0] pcAddr,
	input  logic [15:0] instrData,
	output logic [15:0] memAddr,
	output logic        memRead,
	output logic [15:0] instrReg
);

	logic readPhase;

	assign readPhase = (phase == DECODE);

	// PC is already updated at the end of FETCH
	assign memAddr = pcAddr;
	assign memRead = readPhase;

	// Memory answers in the same cycle, so capture at the end of DECODE
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			instrReg <= NOP_WORD;
		end else if (readPhase) begin
			instrReg <= instrData;
		end
	end

endmodule

//--- hdl/programCounter.sv
//********************
// Program counter
// Next address adder, PC, here, interrupt returns, breakpoint
//********************
`timescale 1ns/1ps

module programCounter import fetchPkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  logic        pcEnable,
	input  phase_t      phase,
	input  pcControl_t  ctrl,
	input  logic [15:0] regB,
	input  bkpCmd_t     bkpCmd,
	output logic [15:0] pcAddr,
	output logic [15:0] here,
	output logic        atBkp
);

	logic [ADDR_W-1:0] argA;
	logic [ADDR_W-1:0] argB;
	logic [ADDR_W-1:0] sum;
	logic [ADDR_W-1:0] nextAddr;
	logic [ADDR_W-1:0] intr0;
	logic [ADDR_W-1:0] intr1;
	logic [ADDR_W-1:0] bkpAddr;
	logic              bkpActive;

	// Offset and base muxes into the adder
	always_comb begin
		case (ctrl.offset)
			OFF_ZERO: argA = '0;
			OFF_TWO:  argA = 16'h0002;
			OFF_FOUR: argA = 16'h0004;
			default:  argA = ctrl.imm;
		endcase

		case (ctrl.base)
			BASE_REGB: argB = regB;
			BASE_ZERO: argB = '0;
			default:   argB = pcAddr;
		endcase

		sum = argA + argB;
	end

	always_comb begin
		case (ctrl.nextSel)
			NEXT_INTV0: nextAddr = INTV0;
			NEXT_INTV1: nextAddr = INTV1;
			NEXT_INTR0: nextAddr = intr0;
			NEXT_INTR1: nextAddr = intr1;
			default:    nextAddr = sum;
		endcase
	end

	// Return addresses, sum is PC+2 when an interrupt is taken
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			intr0 <= '0;
			intr1 <= '0;
		end else if (pcEnable) begin
			if (ctrl.ldInt0) begin
				intr0 <= sum;
			end
			if (ctrl.ldInt1) begin
				intr1 <= sum;
			end
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			pcAddr <= PC_RESET;
			here <= '0;
		end else if (pcEnable) begin
			pcAddr <= nextAddr;
			here <= nextAddr + 16'h0002;
		end
	end

	// Breakpoint register
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			bkpAddr <= '0;
			bkpActive <= 1'b0;
		end else if (bkpCmd.load) begin
			bkpAddr <= bkpCmd.addr;
			bkpActive <= bkpCmd.enable;
		end
	end

	// Compare the upcoming address in COMMIT, stops before the PC loads it
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			atBkp <= 1'b0;
		end else if (bkpCmd.load) begin
			atBkp <= 1'b0;
		end else if (phase == COMMIT) begin
			atBkp <= bkpActive && (nextAddr == bkpAddr);
		end
	end

endmodule

//--- hdl/branchDecoder.sv
//********************
// Branch decoder
// Instruction word and interrupt requests to PC control
//********************
`timescale 1ns/1ps

module branchDecoder import fetchPkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  phase_t      phase,
	input  logic        pcEnable,
	input  logic [15:0] instrReg,
	input  logic        irq0,
	input  logic        irq1,
	output pcControl_t  ctrl,
	output logic        intAck0,
	output logic        intAck1
);

	opcode_t     op;
	logic [11:0] immField;
	logic        irq0Smp;
	logic        irq1Smp;
	logic        inSvc0;
	logic        inSvc1;
	logic        take0;
	logic        take1;
	logic        clr0;
	logic        clr1;

	assign op = opcode_t'(instrReg[15:12]);
	assign immField = instrReg[11:0];

	// Requests sampled with the instruction word, keeps ctrl steady until FETCH
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			irq0Smp <= 1'b0;
			irq1Smp <= 1'b0;
		end else if (phase == DECODE) begin
			irq0Smp <= irq0;
			irq1Smp <= irq1;
		end
	end

	always_comb begin
		ctrl = '{base: BASE_PC, offset: OFF_TWO, nextSel: NEXT_SUM,
			imm: '0, ldInt0: 1'b0, ldInt1: 1'b0};
		take0 = 1'b0;
		take1 = 1'b0;
		clr0 = 1'b0;
		clr1 = 1'b0;
		case (op)
			OP_JMP: begin
				// Absolute, word address doubled
				ctrl.base = BASE_ZERO;
				ctrl.offset = OFF_IMM;
				ctrl.imm = {3'b000, immField, 1'b0};
			end
			OP_JR: begin
				ctrl.offset = OFF_IMM;
				ctrl.imm = {{3{immField[11]}}, immField, 1'b0};
			end
			OP_JREG: begin
				ctrl.base = BASE_REGB;
				ctrl.offset = OFF_ZERO;
			end
			OP_RETI: begin
				// Inner handler is always INT0 when both are in service
				if (inSvc0) begin
					ctrl.nextSel = NEXT_INTR0;
					clr0 = 1'b1;
				end else begin
					ctrl.nextSel = NEXT_INTR1;
					clr1 = 1'b1;
				end
			end
			default: begin
				// NOP and unused opcodes, interrupts may be taken here
				if (irq0Smp && !inSvc0) begin
					take0 = 1'b1;
					ctrl.nextSel = NEXT_INTV0;
					ctrl.ldInt0 = 1'b1;
				end else if (irq1Smp && !inSvc0 && !inSvc1) begin
					take1 = 1'b1;
					ctrl.nextSel = NEXT_INTV1;
					ctrl.ldInt1 = 1'b1;
				end
			end
		endcase
	end

	assign intAck0 = take0 && pcEnable;
	assign intAck1 = take1 && pcEnable;

	// In-service flags
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			inSvc0 <= 1'b0;
			inSvc1 <= 1'b0;
		end else if (pcEnable) begin
			if (take0) begin
				inSvc0 <= 1'b1;
			end else if (clr0) begin
				inSvc0 <= 1'b0;
			end
			if (take1) begin
				inSvc1 <= 1'b1;
			end else if (clr1) begin
				inSvc1 <= 1'b0;
			end
		end
	end

endmodule

//--- hdl/phaseSequencer.sv
//********************
// Phase sequencer
// Steps FETCH, DECODE, EXECUTE, COMMIT once per instruction
//********************
`timescale 1ns/1ps

module phaseSequencer import fetchPkg::*; (
	input  logic   CLK,
	input  logic   RESET,
	input  logic   run,
	input  logic   atBkp,
	output phase_t phase,
	output logic   pcEnable
);

	phase_t nextPhase;

	// Leave FETCH only when running and not parked on a breakpoint
	assign pcEnable = (phase == FETCH) && run && !atBkp;

	always_comb begin
		case (phase)
			FETCH: begin
				nextPhase = pcEnable ? DECODE : FETCH;
			end
			DECODE: begin
				nextPhase = EXECUTE;
			end
			EXECUTE: begin
				nextPhase = COMMIT;
			end
			default: begin
				nextPhase = FETCH;
			end
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase <= FETCH;
		end else begin
			phase <= nextPhase;
		end
	end

endmodule

//--- hdl/fetchPkg.sv
//********************
// Fetch unit package
// Opcodes, phases, PC control encodings and fixed addresses
//********************
package fetchPkg;

	localparam int ADDR_W = 16;

	// Interrupt vectors
	localparam logic [ADDR_W-1:0] INTV0 = 16'h0004;
	localparam logic [ADDR_W-1:0] INTV1 = 16'h0008;

	// First FETCH adds 2 and lands on 0x0000
	localparam logic [ADDR_W-1:0] PC_RESET = 16'hFFFE;
	localparam logic [15:0] NOP_WORD = 16'h0000;

	// Opcode in bits 15..12 of the instruction word
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_JMP  = 4'h1,
		OP_JR   = 4'h2,
		OP_JREG = 4'h3,
		OP_RETI = 4'h4
	} opcode_t;

	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		DECODE  = 2'd1,
		EXECUTE = 2'd2,
		COMMIT  = 2'd3
	} phase_t;

	// Adder base select
	typedef enum logic [1:0] {
		BASE_PC   = 2'd0,
		BASE_REGB = 2'd1,
		BASE_ZERO = 2'd2
	} pcBase_t;

	// Adder offset select
	typedef enum logic [1:0] {
		OFF_ZERO = 2'd0,
		OFF_TWO  = 2'd1,
		OFF_FOUR = 2'd2,
		OFF_IMM  = 2'd3
	} pcOffset_t;

	// Next address source
	typedef enum logic [2:0] {
		NEXT_SUM   = 3'd0,
		NEXT_INTV0 = 3'd1,
		NEXT_INTV1 = 3'd2,
		NEXT_INTR0 = 3'd3,
		NEXT_INTR1 = 3'd4
	} pcNext_t;

	typedef struct packed {
		pcBase_t           base;
		pcOffset_t         offset;
		pcNext_t           nextSel;
		logic [ADDR_W-1:0] imm;
		logic              ldInt0;
		logic              ldInt1;
	} pcControl_t;

	// Debug breakpoint command, load is a single cycle pulse
	typedef struct packed {
		logic              load;
		logic              enable;
		logic [ADDR_W-1:0] addr;
	} bkpCmd_t;

endpackage
